/* compile.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/regfile_if.sv
hdl/control.sv
hdl/regfile.sv
hdl/alu.sv
hdl/data_memory.sv
hdl/pipeline_core.sv
hdl/core_top.sv
bench/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module core_tb -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vcore_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

/* bench/core_stimulus.txt */
// Word count, program words, record count, then one retire record per line
// Record columns are pc, we, rd and data in hex
15
3C011234 // 00 li   r1, 0x1234
3C02FFFD // 04 li   r2, -3
00221820 // 08 add  r3, r1, r2
00612022 // 0C sub  r4, r3, r1
0081282A // 10 slt  r5, r4, r1
00613024 // 14 and  r6, r3, r1
00C53825 // 18 or   r7, r6, r5
00210020 // 1C add  r0, r1, r1
20080005 // 20 addi r8, r0, 5
3C098765 // 24 li   r9, 0x8765
AC090020 // 28 stw  r9, 0x20(r0)
8C0A0020 // 2C ldw  r10, 0x20(r0)
800B0021 // 30 ldb  r11, 0x21(r0)
014B6020 // 34 add  r12, r10, r11
11490001 // 38 beq  r10, r9, +1 taken
3C0D0BAD // 3C li   r13 skipped by the branch
10220005 // 40 beq  r1, r2, +5 not taken
08000014 // 44 jump 0x50
3C0D0BAD // 48 li   r13 flushed
3C0E0BAD // 4C li   r14 flushed
08000014 // 50 jump 0x50 ends the program
13
00000000 1 01 00001234
00000004 1 02 FFFFFFFD
00000008 1 03 00001231
0000000C 1 04 FFFFFFFD
00000010 1 05 00000001
00000014 1 06 00001230
00000018 1 07 00001231
0000001C 1 00 00002468
00000020 1 08 00000005
00000024 1 09 FFFF8765
00000028 0 00 00000000
0000002C 1 0A FFFF8765
00000030 1 0B 00000087
00000034 1 0C FFFF87EC
00000038 0 00 00000000
00000040 0 00 00000000
00000044 0 00 00000000
00000050 0 00 00000000
00000050 0 00 00000000

/* bench/core_tb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb;

	localparam int IMEM_AW   = $clog2(`CORE_IMEM_WORDS);
	localparam int STIM_SIZE = 512; // Room for the program and the record table

	logic                  clk;
	logic                  rst_n;
	logic                  start;
	logic                  imem_we;
	logic [IMEM_AW-1:0]    imem_addr;
	logic [`CORE_XLEN-1:0] imem_data;
	logic                  retire_valid;
	logic [`CORE_XLEN-1:0] retire_pc;
	logic                  retire_we;
	logic [4:0]            retire_rd;
	logic [`CORE_XLEN-1:0] retire_data;
	logic                  retire_credit = 1'b0; // Driven by the credit process only

	logic [`CORE_XLEN-1:0] stim [STIM_SIZE]; // Raw words of the stimulus file
	int word_count;    // Program length in words
	int rec_count;     // Number of expected retire records
	int rec_base;      // Index of the first record word in stim
	int rec_idx;       // Next record to compare
	int errors;
	int model_credits = `CORE_RETIRE_CREDITS; // Credits the core holds after the next edge
	int cycle;         // Falling edges seen so far
	int due [$];       // Cycles at which consumed credits are handed back
	bit started;       // Start has been pulsed
	bit done;          // Every expected record has been seen

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	core_top dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.imem_we       (imem_we),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.retire_valid  (retire_valid),
		.retire_pc     (retire_pc),
		.retire_we     (retire_we),
		.retire_rd     (retire_rd),
		.retire_data   (retire_data),
		.retire_credit (retire_credit)
	);

	// Compares the record on the retire port with table entry n
	task automatic check_record(input int n);
		logic [`CORE_XLEN-1:0] exp_pc, exp_we, exp_rd, exp_data;
		string expect_text, got_text;
		exp_pc   = stim[rec_base + 4 * n];
		exp_we   = stim[rec_base + 4 * n + 1];
		exp_rd   = stim[rec_base + 4 * n + 2];
		exp_data = stim[rec_base + 4 * n + 3];
		if (retire_pc !== exp_pc || retire_we !== exp_we[0] || retire_rd !== exp_rd[4:0] ||
			retire_data !== exp_data) begin
			errors++;
			expect_text = $sformatf("pc %h we %0d rd %0d data %h",
				exp_pc, exp_we[0], exp_rd[4:0], exp_data);
			got_text = $sformatf("pc %h we %0d rd %0d data %h",
				retire_pc, retire_we, retire_rd, retire_data);
			$display("mismatch at %0t: record %0d expected %s, got %s",
				$time, n, expect_text, got_text);
		end
	endtask

	task automatic report_counts();
		$display("records checked %0d of %0d, errors %0d", rec_idx, rec_count, errors);
	endtask

	// Resets the core, loads the program and waits for the whole record table
	task automatic run_program();
		repeat (4) @(posedge clk); // Four rising edges under reset
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < word_count; i++) begin
			imem_we   = 1'b1;
			imem_addr = IMEM_AW'(i);
			imem_data = stim[1 + i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		repeat (3) @(negedge clk); // Idle with start low so retire_valid must stay quiet
		started = 1'b1;
		start   = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait (rec_idx == rec_count);
	endtask

	// Samples the retire port and hands credits back on every falling edge
	always @(negedge clk) begin
		int pick;
		cycle++;
		if (!started && retire_valid !== 1'b0) begin
			errors++;
			$display("retire_valid was high at %0t before start", $time);
		end
		if (retire_valid === 1'b1) begin
			if (model_credits <= 0) begin
				errors++;
				$display("the core retired at %0t while it held no credit", $time);
			end
			if (rec_idx < rec_count) begin
				check_record(rec_idx);
				rec_idx++; // Later loops of the final jump are not compared
			end
			due.push_back(cycle + 1 + int'($urandom_range(6, 0))); // Returned 0 to 6 cycles on
		end
		pick = -1;
		for (int i = 0; i < due.size(); i++) begin
			if (pick < 0 && due[i] <= cycle) begin
				pick = i;
			end
		end
		if (pick >= 0) begin
			due.delete(pick);
			retire_credit = 1'b1; // The port takes one credit per cycle
			model_credits++;
		end else begin
			retire_credit = 1'b0;
		end
		if (retire_valid === 1'b1) begin
			model_credits--; // Spent at the coming rising edge
		end
	end

	initial begin
		void'($urandom(32'h6fcc));
		rst_n     = 1'b0;
		start     = 1'b0;
		imem_we   = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		$readmemh("bench/core_stimulus.txt", stim);
		word_count = int'(stim[0]);
		rec_count  = int'(stim[word_count + 1]); // Count word follows the program
		rec_base   = word_count + 2;
		if (word_count < 1 || word_count > `CORE_IMEM_WORDS || rec_count < 1 ||
			rec_base + 4 * rec_count > STIM_SIZE) begin
			$display("the stimulus file holds no usable program or record table");
			report_counts();
			$display("Something failed");
		end else begin
			run_program();
			done = 1'b1;
			report_counts();
			if (errors == 0) begin
				$display("Everything OK");
			end else begin
				$display("Something failed");
			end
		end
		$finish;
	end

	// Allows 40 cycles per record plus reset and program load
	initial begin
		wait (rec_count != 0);
		repeat (40 * rec_count + word_count + 20) @(posedge clk);
		if (!done) begin
			$display("timeout with only %0d of %0d retire records seen", rec_idx, rec_count);
			report_counts();
			$display("Something failed");
			$finish;
		end
	end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start,
	input  logic                                imem_we,
	input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] imem_addr,
	input  logic [`CORE_XLEN-1:0]               imem_data,
	output logic                                retire_valid,
	output logic [`CORE_XLEN-1:0]               retire_pc,
	output logic                                retire_we,
	output logic [4:0]                          retire_rd,
	output logic [`CORE_XLEN-1:0]               retire_data,
	input  logic                                retire_credit
);

	regfile_if rf_bus (); // Decode reads and writeback writes

	pipeline_core core_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.imem_we       (imem_we),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.rf            (rf_bus.core),
		.retire_valid  (retire_valid),
		.retire_pc     (retire_pc),
		.retire_we     (retire_we),
		.retire_rd     (retire_rd),
		.retire_data   (retire_data),
		.retire_credit (retire_credit)
	);

	regfile regfile_i (
		.clk   (clk),
		.rst_n (rst_n),
		.rf    (rf_bus.file)
	);

endmodule

/* hdl/pipeline_core.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module pipeline_core (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start,     // Lets fetch begin
	input  logic                                imem_we,   // Program load strobe
	input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] imem_addr, // Word index of the load
	input  logic [`CORE_XLEN-1:0]               imem_data,
	regfile_if.core                             rf,
	output logic                                retire_valid,
	output logic [`CORE_XLEN-1:0]               retire_pc,
	output logic                                retire_we,
	output logic [4:0]                          retire_rd,
	output logic [`CORE_XLEN-1:0]               retire_data,
	input  logic                                retire_credit // One credit back per cycle high
);

	localparam int IMEM_AW = $clog2(`CORE_IMEM_WORDS);
	localparam int CRED_W  = $clog2(`CORE_RETIRE_CREDITS + 1);

	logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_WORDS]; // Loaded by the testbench
	logic running; // Set once start is seen
	logic [`CORE_XLEN-1:0] pc;
	logic [CRED_W-1:0] credits;
	logic freeze, hazard, taken, flush; // Pipeline-wide hold and redirect terms
	logic ifid_valid;
	logic [`CORE_XLEN-1:0] ifid_pc, ifid_instr;
	core_pkg::opcode_e id_opcode, ctl_opcode;
	logic ctl_stall, id_is_rtype, id_uses_rs, id_uses_rt, ex_wr, mem_wr;
	logic [4:0] id_rs, id_rt, id_rd;
	logic [`CORE_XLEN-1:0] id_simm;
	logic idex_valid;
	core_pkg::opcode_e idex_opcode;
	core_pkg::ctrl_t idex_ctrl; // Registered inside control
	core_pkg::alu_op_e idex_alu_op;
	logic [`CORE_XLEN-1:0] idex_pc, idex_a, idex_rt_val, idex_imm, idex_target;
	logic [4:0] idex_dest;
	logic [`CORE_XLEN-1:0] alu_b, alu_result, mem_rdata;
	logic alu_equal;
	logic exmem_valid, exmem_equal;
	core_pkg::ctrl_t exmem_ctrl;
	logic [`CORE_XLEN-1:0] exmem_pc, exmem_alu, exmem_store, exmem_target;
	logic [4:0] exmem_dest;
	logic memwb_valid;
	core_pkg::ctrl_t memwb_ctrl;
	logic [`CORE_XLEN-1:0] memwb_pc, memwb_data;
	logic [4:0] memwb_dest;

	// Writeback holds an instruction it may not retire so every stage waits
	assign freeze       = memwb_valid && credits == '0;
	assign retire_valid = memwb_valid && credits != '0;
	assign taken        = exmem_ctrl.jump || (exmem_ctrl.branch && exmem_equal);
	assign flush        = taken && !freeze; // Kills IF, ID and EX
	assign id_opcode    = core_pkg::opcode_e'(ifid_instr[31:26]);
	assign id_is_rtype  = (id_opcode == core_pkg::op_rtype);
	assign id_rs        = ifid_instr[25:21];
	assign id_rt        = ifid_instr[20:16];
	assign id_rd        = ifid_instr[15:11];
	assign id_simm      = {{(`CORE_XLEN-16){ifid_instr[15]}}, ifid_instr[15:0]};
	assign rf.rs_addr   = id_rs;
	assign rf.rt_addr   = id_rt;

	always_comb begin
		id_uses_rs = 1'b0;
		id_uses_rt = 1'b0; // LI and JUMP read no register
		case (id_opcode)
			core_pkg::op_rtype, core_pkg::op_beq, core_pkg::op_stb, core_pkg::op_stw: begin
				id_uses_rs = 1'b1;
				id_uses_rt = 1'b1;
			end
			core_pkg::op_ldb, core_pkg::op_ldw, core_pkg::op_addi: id_uses_rs = 1'b1;
			default: ;
		endcase
	end

	// No forwarding so any pending write in EX or MEM blocks decode
	assign ex_wr  = idex_ctrl.regwrite && idex_dest != 5'd0;
	assign mem_wr = exmem_ctrl.regwrite && exmem_dest != 5'd0;
	assign hazard = ifid_valid && (
		(id_uses_rs && ((ex_wr && idex_dest == id_rs) || (mem_wr && exmem_dest == id_rs))) ||
		(id_uses_rt && ((ex_wr && idex_dest == id_rt) || (mem_wr && exmem_dest == id_rt))));

	// A freeze replays the held execute instruction so its bundle survives
	assign ctl_opcode = freeze ? idex_opcode : id_opcode;
	assign ctl_stall  = freeze ? !idex_valid : (hazard || flush || !ifid_valid);

	control control_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.stall  (ctl_stall),
		.opcode (ctl_opcode),
		.ctrl   (idex_ctrl)
	);

	always_ff @(posedge clk) begin
		if (imem_we) imem[imem_addr] <= imem_data; // Program load port
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running     <= 1'b0;
			pc          <= '0;
			ifid_valid  <= 1'b0;
			idex_valid  <= 1'b0;
			exmem_valid <= 1'b0;
			exmem_ctrl  <= '0;
			memwb_valid <= 1'b0;
			memwb_ctrl  <= '0;
			credits     <= CRED_W'(`CORE_RETIRE_CREDITS);
		end else begin
			if (start) running <= 1'b1;
			if (flush) begin
				pc         <= exmem_target; // Redirect from the memory stage
				ifid_valid <= 1'b0;
			end else if (!freeze && !hazard) begin
				ifid_valid <= running; // Bubbles until start
				if (running) pc <= pc + 4;
			end
			if (!freeze) begin
				idex_valid  <= ifid_valid && !hazard && !flush; // Interlock bubble
				exmem_valid <= idex_valid && !flush;
				exmem_ctrl  <= flush ? '0 : idex_ctrl;
				memwb_valid <= exmem_valid;
				memwb_ctrl  <= exmem_ctrl;
			end
			credits <= credits - CRED_W'(retire_valid) + CRED_W'(retire_credit);
		end
	end

	// Stage payload moves only when its valid bit could move
	always_ff @(posedge clk) begin
		if (!freeze && !hazard) begin
			ifid_pc    <= pc;
			ifid_instr <= imem[pc[IMEM_AW+1:2]];
		end
		if (!freeze) begin
			idex_opcode <= id_opcode;
			idex_pc     <= ifid_pc;
			idex_a      <= (id_opcode == core_pkg::op_li) ? '0 : rf.rs_data;
			idex_rt_val <= rf.rt_data;
			idex_imm    <= id_simm;
			idex_dest   <= id_is_rtype ? id_rd : id_rt; // Immediates and loads write rt
			idex_alu_op <= id_is_rtype ? core_pkg::alu_op_e'(ifid_instr[5:0]) : core_pkg::alu_add;
			idex_target <= (id_opcode == core_pkg::op_jump) ?
				{{(`CORE_XLEN-28){1'b0}}, ifid_instr[25:0], 2'b00} :
				ifid_pc + 4 + {id_simm[`CORE_XLEN-3:0], 2'b00};
			exmem_pc     <= idex_pc;
			exmem_alu    <= alu_result;
			exmem_store  <= idex_rt_val;
			exmem_equal  <= alu_equal;
			exmem_target <= idex_target;
			exmem_dest   <= idex_dest;
			memwb_pc     <= exmem_pc;
			memwb_data   <= exmem_ctrl.regwrite ?
				(exmem_ctrl.memtoreg ? mem_rdata : exmem_alu) : '0; // Zero for non-writers
			memwb_dest   <= exmem_ctrl.regwrite ? exmem_dest : 5'd0;
		end
	end

	assign alu_b = idex_ctrl.alusrc_reg ? idex_rt_val : idex_imm;

	alu alu_i (
		.op     (idex_alu_op),
		.a      (idex_a),
		.b      (alu_b),
		.result (alu_result),
		.equal  (alu_equal)
	);

	data_memory dmem_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.addr     (exmem_alu[7:0]),
		.wdata    (exmem_store),
		.read     (exmem_ctrl.memread),
		.write    (exmem_ctrl.memwrite && !freeze), // A held store commits once
		.byteword (exmem_ctrl.byteword),
		.rdata    (mem_rdata)
	);

	assign rf.wr_en    = retire_valid && memwb_ctrl.regwrite; // Write only as it retires
	assign rf.wr_addr  = memwb_dest;
	assign rf.wr_data  = memwb_data;
	assign retire_pc   = memwb_pc;
	assign retire_we   = memwb_ctrl.regwrite;
	assign retire_rd   = memwb_dest;
	assign retire_data = memwb_data;

	// Credits never exceed what the core owned after reset
	a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CRED_W'(`CORE_RETIRE_CREDITS));

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module data_memory (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  addr,     // Byte address from the ALU
	input  logic [31:0] wdata,    // Store data taken from rt
	input  logic        read,
	input  logic        write,
	input  logic        byteword, // Word access when set
	output logic [31:0] rdata     // Valid in the same cycle as the address
);

	logic [7:0] mem [`CORE_DMEM_BYTES]; // Little-endian byte array

	// Stores land on the clock edge
	always_ff @(posedge clk) begin
		if (write) begin
			if (byteword) begin
				mem[{addr[7:2], 2'd0}] <= wdata[7:0];   // Lowest byte at lowest address
				mem[{addr[7:2], 2'd1}] <= wdata[15:8];
				mem[{addr[7:2], 2'd2}] <= wdata[23:16];
				mem[{addr[7:2], 2'd3}] <= wdata[31:24];
			end else begin
				mem[addr] <= wdata[7:0]; // Only the addressed lane changes
			end
		end
	end

	always_comb begin
		if (!read) begin
			rdata = '0;
		end else if (byteword) begin
			rdata = {mem[{addr[7:2], 2'd3}], mem[{addr[7:2], 2'd2}],
				mem[{addr[7:2], 2'd1}], mem[{addr[7:2], 2'd0}]};
		end else begin
			rdata = {24'd0, mem[addr]}; // Byte loads zero-extend
		end
	end

	// Word accesses must sit on a four-byte boundary
	a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) && byteword |-> addr[1:0] == 2'b00);

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu (
	input  core_pkg::alu_op_e      op,     // Operation chosen in decode
	input  logic [`CORE_XLEN-1:0]  a,      // rs value or zero for LI
	input  logic [`CORE_XLEN-1:0]  b,      // rt value or sign-extended immediate
	output logic [`CORE_XLEN-1:0]  result,
	output logic                   equal   // Operands match so a BEQ is taken
);

	logic less; // Signed comparison for set-less-than

	assign less  = $signed(a) < $signed(b);
	assign equal = (a == b);

	always_comb begin
		case (op)
			core_pkg::alu_add: result = a + b;
			core_pkg::alu_sub: result = a - b;
			core_pkg::alu_and: result = a & b;
			core_pkg::alu_or:  result = a | b;
			core_pkg::alu_slt: result = {{(`CORE_XLEN-1){1'b0}}, less}; // One or zero
			default:           result = '0; // Undefined funct codes give zero
		endcase
	end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module regfile (
	input  logic clk,
	input  logic rst_n,
	regfile_if.file rf
);

	logic [`CORE_XLEN-1:0] regs [32]; // Register 0 is never written

	// One read port with write bypass and a hard zero for register 0
	function automatic logic [`CORE_XLEN-1:0] read_port(input logic [4:0] addr);
		logic [`CORE_XLEN-1:0] value;
		if (addr == 5'd0) begin
			value = '0;
		end else if (rf.wr_en && rf.wr_addr == addr) begin
			value = rf.wr_data; // Same-cycle write is visible to decode
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0; // Every register starts at zero
			end
		end else if (rf.wr_en && rf.wr_addr != 5'd0) begin
			regs[rf.wr_addr] <= rf.wr_data; // Writes to register 0 are dropped
		end
	end

	always_comb begin
		rf.rs_data = read_port(rf.rs_addr);
		rf.rt_data = read_port(rf.rt_addr);
	end

endmodule

/* hdl/control.sv */
`timescale 1ns/1ps

module control (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,  // Forces a bubble into execute
	input  core_pkg::opcode_e opcode, // Opcode of the instruction in decode
	output core_pkg::ctrl_t   ctrl    // Bundle seen by execute one clock later
);

	core_pkg::ctrl_t decoded; // Combinational decode of the current opcode

	always_comb begin
		decoded = '0; // Unknown opcodes do nothing at all
		case (opcode)
			core_pkg::op_rtype: begin
				decoded.regwrite   = 1'b1; // Result goes to rd
				decoded.alusrc_reg = 1'b1; // Both operands from registers
			end
			core_pkg::op_ldb: begin
				decoded.regwrite = 1'b1;
				decoded.memtoreg = 1'b1; // Load data is written back
				decoded.memread  = 1'b1; // Byte lane selected since byteword stays low
			end
			core_pkg::op_ldw: begin
				decoded.regwrite = 1'b1;
				decoded.memtoreg = 1'b1;
				decoded.memread  = 1'b1;
				decoded.byteword = 1'b1; // All four lanes
			end
			core_pkg::op_stb: begin
				decoded.memwrite = 1'b1; // Address is rs plus immediate
			end
			core_pkg::op_stw: begin
				decoded.memwrite = 1'b1;
				decoded.byteword = 1'b1;
			end
			core_pkg::op_beq: begin
				decoded.branch     = 1'b1; // Taken only when the ALU flags equality
				decoded.alusrc_reg = 1'b1; // Compare rs against rt
			end
			core_pkg::op_jump: begin
				decoded.jump = 1'b1; // Always redirects in the memory stage
			end
			core_pkg::op_li: begin
				decoded.regwrite = 1'b1; // Zero plus immediate lands in rt
			end
			core_pkg::op_addi: begin
				decoded.regwrite = 1'b1; // rs plus immediate lands in rt
			end
			default: begin
				decoded = '0;
			end
		endcase
	end

	// One clock from opcode to bundle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (stall) begin
			ctrl <= '0; // Bubble with no writes and no memory access
		end else begin
			ctrl <= decoded;
		end
	end

	// A single instruction never both loads and stores
	a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.memread && ctrl.memwrite));

endmodule

/* hdl/regfile_if.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

interface regfile_if;

	logic [4:0]            rs_addr; // First read address from decode
	logic [4:0]            rt_addr; // Second read address from decode
	logic [`CORE_XLEN-1:0] rs_data; // First read data
	logic [`CORE_XLEN-1:0] rt_data; // Second read data
	logic                  wr_en;   // Write strobe from writeback
	logic [4:0]            wr_addr; // Destination register of the retiring instruction
	logic [`CORE_XLEN-1:0] wr_data; // Result of the retiring instruction

	// Pipeline side drives addresses and the write port
	modport core (
		output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
		input  rs_data, rt_data
	);

	// Register file side answers the reads
	modport file (
		input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
		output rs_data, rt_data
	);

endinterface

/* hdl/core_pkg.sv */
package core_pkg;

	// Primary opcodes in instruction bits 31 to 26
	typedef enum logic [5:0] {
		op_rtype = 6'h00, // Register-type ALU group selected by funct
		op_jump  = 6'h02, // Absolute jump to target26 times four
		op_beq   = 6'h04, // Branch when rs equals rt
		op_addi  = 6'h08, // rt gets rs plus sign-extended immediate
		op_li    = 6'h0f, // rt gets sign-extended immediate
		op_ldb   = 6'h20, // Byte load with zero extension
		op_ldw   = 6'h23, // Word load
		op_stb   = 6'h28, // Byte store of the low byte of rt
		op_stw   = 6'h2b  // Word store of rt
	} opcode_e;

	// Function codes in bits 5 to 0 of register-type instructions
	typedef enum logic [5:0] {
		alu_add = 6'h20, // Two's complement sum
		alu_sub = 6'h22, // Two's complement difference
		alu_and = 6'h24, // Bitwise and
		alu_or  = 6'h25, // Bitwise or
		alu_slt = 6'h2a  // Signed set-less-than
	} alu_op_e;

	// Control bundle produced in decode and carried down the pipe
	typedef struct packed {
		logic regwrite;   // Writeback writes the destination register
		logic memtoreg;   // Writeback takes load data instead of the ALU result
		logic branch;     // Conditional redirect in the memory stage
		logic jump;       // Unconditional redirect in the memory stage
		logic memwrite;   // Store in the memory stage
		logic memread;    // Load in the memory stage
		logic byteword;   // Word access when set and byte access when clear
		logic alusrc_reg; // Second ALU operand comes from rt instead of the immediate
	} ctrl_t;

endpackage

/* hdl/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and instruction word width in bits
`define CORE_XLEN 32

// Depth of the instruction memory in 32-bit words
`define CORE_IMEM_WORDS 64

// Size of the data memory in bytes
`define CORE_DMEM_BYTES 256

// Retire credits the core owns right after reset
`define CORE_RETIRE_CREDITS 4

`endif
